//--- src/mini_mcu_pkg.sv
/* OBI request and response structs, internal routed bus types,
   target enum and address map of the microcontroller fabric */
package mini_mcu_pkg;

  // OBI master port
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // request after arbitration, mid names the issuing master
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        mid;
  } bus_req_t;

  typedef struct packed {
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
    logic        mid;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_SLOW   = 2'd2,
    TGT_NONE   = 2'd3
  } target_e;

  // address map
  localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [31:0] PERIPH_BASE = 32'h2000_0000;
  localparam logic [31:0] PERIPH_MASK = 32'hFFFF_F000;
  localparam logic [31:0] SLOW_BASE   = 32'h3000_0000;
  localparam logic [31:0] SLOW_MASK   = 32'hFFFF_F000;

  localparam logic [11:0] EXIT_VALUE_OFFSET = 12'h000;
  localparam logic [11:0] EXIT_VALID_OFFSET = 12'h004;

  localparam logic [31:0] ERR_RDATA = 32'hBADCAB1E;

endpackage

//--- src/obi_master_arbiter.sv
/* round-robin arbiter for the instruction and data OBI masters,
   tags the winner with its master id and steers responses back */
`timescale 1ns/1ns

module obi_master_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  mini_mcu_pkg::obi_req_t    instr_req_i,
  output mini_mcu_pkg::obi_resp_t   instr_resp_o,
  input  mini_mcu_pkg::obi_req_t    data_req_i,
  output mini_mcu_pkg::obi_resp_t   data_resp_o,
  output mini_mcu_pkg::bus_req_t    bus_req_o,
  input  logic                      bus_ready_i,
  input  mini_mcu_pkg::bus_rsp_t [1:0] bus_rsp_i
);

  import mini_mcu_pkg::*;

  // set while the data master wins a tie
  logic     prio_q;
  logic     sel_data;
  logic     tie_xfer;
  obi_req_t sel_req;

  assign sel_data = data_req_i.req && (!instr_req_i.req || prio_q);
  assign sel_req  = sel_data ? data_req_i : instr_req_i;
  assign tie_xfer = instr_req_i.req && data_req_i.req && bus_ready_i;

  assign bus_req_o = '{
    req:   instr_req_i.req || data_req_i.req,
    we:    sel_req.we,
    be:    sel_req.be,
    addr:  sel_req.addr,
    wdata: sel_req.wdata,
    mid:   sel_data
  };

  // served master drops to low priority
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q <= 1'b0;
    end else if (bus_req_o.req && bus_ready_i) begin
      prio_q <= ~sel_data;
    end
  end

  always_comb begin
    instr_resp_o     = '0;
    data_resp_o      = '0;
    instr_resp_o.gnt = bus_ready_i && instr_req_i.req && !sel_data;
    data_resp_o.gnt  = bus_ready_i && sel_data;
    for (int i = 0; i < 2; i++) begin
      if (bus_rsp_i[i].rvalid) begin
        if (bus_rsp_i[i].mid) begin
          data_resp_o.rvalid = 1'b1;
          data_resp_o.err    = bus_rsp_i[i].err;
          data_resp_o.rdata  = bus_rsp_i[i].rdata;
        end else begin
          instr_resp_o.rvalid = 1'b1;
          instr_resp_o.err    = bus_rsp_i[i].err;
          instr_resp_o.rdata  = bus_rsp_i[i].rdata;
        end
      end
    end
  end

  // the loser of a tie wins the next one
  a_rr_alternate: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tie_xfer |=> !tie_xfer || (data_resp_o.gnt != $past(data_resp_o.gnt))
  );

endmodule

//--- src/obi_addr_decoder.sv
/* address decoder with per-target busy tracking, local error
   responder for unmapped accesses and response merge by master id */
`timescale 1ns/1ns

module obi_addr_decoder #(
  parameter int NUM_BYTES = 4096
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  mini_mcu_pkg::bus_req_t       bus_req_i,
  output logic                         bus_ready_o,
  output mini_mcu_pkg::bus_rsp_t [1:0] bus_rsp_o,
  output mini_mcu_pkg::bus_req_t       ram_req_o,
  output mini_mcu_pkg::bus_req_t       periph_req_o,
  output mini_mcu_pkg::bus_req_t       slow_req_o,
  input  mini_mcu_pkg::bus_rsp_t       ram_rsp_i,
  input  mini_mcu_pkg::bus_rsp_t       periph_rsp_i,
  input  mini_mcu_pkg::bus_rsp_t       slow_rsp_i
);

  import mini_mcu_pkg::*;

  localparam logic [31:0] RAM_MASK = ~(32'(NUM_BYTES) - 32'd1);

  target_e        tgt;
  logic           tgt_busy;
  logic           accept;
  logic [2:0]     busy_q;
  logic [2:0]     busy_d;
  bus_req_t [2:0] tgt_req_q;
  logic           err_valid_q;
  logic           err_mid_q;
  bus_rsp_t [3:0] rsp_all;
  logic [3:0]     rsp_vld;
  logic [3:0]     rsp_mid;

  always_comb begin
    if ((bus_req_i.addr & RAM_MASK) == RAM_BASE) begin
      tgt = TGT_RAM;
    end else if ((bus_req_i.addr & PERIPH_MASK) == PERIPH_BASE) begin
      tgt = TGT_PERIPH;
    end else if ((bus_req_i.addr & SLOW_MASK) == SLOW_BASE) begin
      tgt = TGT_SLOW;
    end else begin
      tgt = TGT_NONE;
    end
  end

  always_comb begin
    case (tgt)
      TGT_RAM:    tgt_busy = busy_q[0];
      TGT_PERIPH: tgt_busy = busy_q[1];
      TGT_SLOW:   tgt_busy = busy_q[2];
      default:    tgt_busy = 1'b0;
    endcase
  end

  assign bus_ready_o = !tgt_busy;
  assign accept      = bus_req_i.req && bus_ready_o;

  // index of rsp_all follows target_e
  assign rsp_all[TGT_RAM]    = ram_rsp_i;
  assign rsp_all[TGT_PERIPH] = periph_rsp_i;
  assign rsp_all[TGT_SLOW]   = slow_rsp_i;
  assign rsp_all[TGT_NONE]   = '{rvalid: err_valid_q, err: 1'b1, rdata: ERR_RDATA,
                                 mid: err_mid_q};

  always_comb begin
    for (int t = 0; t < 4; t++) begin
      rsp_vld[t] = rsp_all[t].rvalid;
      rsp_mid[t] = rsp_all[t].mid;
    end
  end

  always_comb begin
    busy_d = busy_q & ~rsp_vld[2:0];
    if (accept && tgt != TGT_NONE) begin
      busy_d[tgt] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= '0;
      err_valid_q <= 1'b0;
    end else begin
      busy_q      <= busy_d;
      err_valid_q <= accept && (tgt == TGT_NONE);
    end
    err_mid_q <= bus_req_i.mid;
  end

  // request copy per target, req bit only on the chosen one
  always_ff @(posedge clk_i) begin
    for (int t = 0; t < 3; t++) begin
      tgt_req_q[t] <= bus_req_i;
      if (!rst_n_i) begin
        tgt_req_q[t].req <= 1'b0;
      end else begin
        tgt_req_q[t].req <= accept && (tgt == target_e'(t));
      end
    end
  end

  assign ram_req_o    = tgt_req_q[TGT_RAM];
  assign periph_req_o = tgt_req_q[TGT_PERIPH];
  assign slow_req_o   = tgt_req_q[TGT_SLOW];

  always_comb begin
    bus_rsp_o = '0;
    for (int t = 0; t < 4; t++) begin
      if (rsp_vld[t]) begin
        bus_rsp_o[rsp_mid[t]] = rsp_all[t];
      end
    end
  end

  // one outstanding transfer per master
  a_rsp_per_mid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $countones(rsp_vld & rsp_mid) <= 1 && $countones(rsp_vld & ~rsp_mid) <= 1
  );

endmodule

//--- src/memory_subsystem.sv
/* on-chip RAM of two byte-enabled banks, one-cycle read latency */
`timescale 1ns/1ns

module memory_subsystem #(
  parameter int NUM_BYTES = 4096
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::bus_rsp_t rsp_o
);

  localparam int AW         = $clog2(NUM_BYTES);
  localparam int BANK_WORDS = NUM_BYTES / 8;

  logic [31:0] bank_q [2][BANK_WORDS];
  logic        bank_sel;
  logic [AW-4:0] word_idx;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        mid_q;

  // upper offset bit picks the bank
  assign bank_sel = req_i.addr[AW-1];
  assign word_idx = req_i.addr[AW-2:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          bank_q[bank_sel][word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= bank_q[bank_sel][word_idx];
      mid_q   <= req_i.mid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{
    rvalid: rvalid_q,
    err:    1'b0,
    rdata:  rdata_q,
    mid:    mid_q
  };

endmodule

//--- src/peripheral_subsystem.sv
/* peripheral target with the exit value and exit valid registers */
`timescale 1ns/1ns

module peripheral_subsystem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::bus_rsp_t rsp_o,
  output logic [31:0]            exit_value_o,
  output logic                   exit_valid_o
);

  import mini_mcu_pkg::*;

  logic [11:0] offset;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        mid_q;

  assign offset = req_i.addr[11:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (req_i.req && req_i.we) begin
        if (offset == EXIT_VALUE_OFFSET) begin
          exit_value_q <= req_i.wdata;
        end
        if (offset == EXIT_VALID_OFFSET) begin
          exit_valid_q <= req_i.wdata[0];
        end
      end
    end
  end

  // read mux, unused offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      mid_q <= req_i.mid;
      case (offset)
        EXIT_VALUE_OFFSET: rdata_q <= exit_value_q;
        EXIT_VALID_OFFSET: rdata_q <= {31'd0, exit_valid_q};
        default:           rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o        = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q, mid: mid_q};
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

//--- src/slow_memory.sv
/* 128-word byte-enabled memory with an LFSR-driven response latency
   of 1 to 4 cycles */
`timescale 1ns/1ns

module slow_memory (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::bus_rsp_t rsp_o
);

  logic [31:0] mem_q [128];
  logic [6:0]  word_idx;
  logic [7:0]  lfsr_q;
  logic [1:0]  cnt_q;
  logic        pending_q;
  logic        rvalid;
  logic [31:0] rdata_q;
  logic        mid_q;

  assign word_idx = req_i.addr[8:2];
  assign rvalid   = pending_q && (cnt_q == 2'd0);

  // x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else if (req_i.req) begin
      pending_q <= 1'b1;
      cnt_q     <= lfsr_q[1:0];
    end else if (rvalid) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      cnt_q <= cnt_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem_q[word_idx];
      mid_q   <= req_i.mid;
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp_o = '{rvalid: rvalid, err: 1'b0, rdata: rdata_q, mid: mid_q};

  // decoder must hold off while a response is still pending
  a_no_overlap: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> !pending_q
  );

endmodule

//--- src/mini_mcu_top.sv
/* bus fabric top: master arbiter, address decoder, RAM,
   peripheral block and slow memory */
`timescale 1ns/1ns

module mini_mcu_top #(
  parameter int NUM_BYTES = 4096
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mini_mcu_pkg::obi_req_t  instr_req_i,
  output mini_mcu_pkg::obi_resp_t instr_resp_o,
  input  mini_mcu_pkg::obi_req_t  data_req_i,
  output mini_mcu_pkg::obi_resp_t data_resp_o,
  output logic [31:0]             exit_value_o,
  output logic                    exit_valid_o
);

  import mini_mcu_pkg::*;

  bus_req_t       bus_req;
  logic           bus_ready;
  bus_rsp_t [1:0] bus_rsp;
  bus_req_t       ram_req;
  bus_rsp_t       ram_rsp;
  bus_req_t       periph_req;
  bus_rsp_t       periph_rsp;
  bus_req_t       slow_req;
  bus_rsp_t       slow_rsp;

  obi_master_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_i),
    .instr_resp_o(instr_resp_o),
    .data_req_i  (data_req_i),
    .data_resp_o (data_resp_o),
    .bus_req_o   (bus_req),
    .bus_ready_i (bus_ready),
    .bus_rsp_i   (bus_rsp)
  );

  obi_addr_decoder #(
    .NUM_BYTES(NUM_BYTES)
  ) u_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req),
    .bus_ready_o (bus_ready),
    .bus_rsp_o   (bus_rsp),
    .ram_req_o   (ram_req),
    .periph_req_o(periph_req),
    .slow_req_o  (slow_req),
    .ram_rsp_i   (ram_rsp),
    .periph_rsp_i(periph_rsp),
    .slow_rsp_i  (slow_rsp)
  );

  memory_subsystem #(
    .NUM_BYTES(NUM_BYTES)
  ) u_memory (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (ram_req),
    .rsp_o  (ram_rsp)
  );

  peripheral_subsystem u_periph (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (periph_req),
    .rsp_o       (periph_rsp),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  slow_memory u_slow_mem (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (slow_req),
    .rsp_o  (slow_rsp)
  );

endmodule

//--- dv/tb_mini_mcu.sv
/* testbench for the bus fabric: clock and reset, two OBI master drivers,
   reference memory model, response comparator and timeout */
`timescale 1ns/1ns

module tb_mini_mcu;

  import mini_mcu_pkg::*;

  localparam int NUM_BYTES       = 4096;
  localparam int HALF_PERIOD     = 50;
  localparam int SAMPLE_DLY      = 40;
  localparam int MAX_XFERS       = 400;
  localparam int MAX_XFER_CYCLES = 6;
  localparam int TIMEOUT_CYCLES  = MAX_XFERS * MAX_XFER_CYCLES + 1600;
  localparam logic [31:0] EXP_ERR_RDATA = 32'hBADCAB1E;

  // expected response with absolute due cycles
  typedef struct packed {
    logic        chk_data;
    logic        err;
    logic [31:0] rdata;
    int          due_min;
    int          due_max;
  } exp_t;

  logic        clk_i;
  logic        rst_n_i;
  obi_req_t    instr_req_i;
  obi_resp_t   instr_resp_o;
  obi_req_t    data_req_i;
  obi_resp_t   data_resp_o;
  logic [31:0] exit_value_o;
  logic        exit_valid_o;

  integer seed;
  int     cycle_cnt = 0;
  int     error_cnt = 0;
  int     check_cnt = 0;
  int     tie_cnt = 0;
  string  test_name;
  event   sample_ev;
  logic   have_last = 1'b0;
  logic   last_mid = 1'b0;

  exp_t        instr_q[$];
  exp_t        data_q[$];
  logic [31:0] mem_m[logic [29:0]];
  logic [31:0] exit_value_m;
  logic        exit_valid_m;
  logic [31:0] ram_addrs[$];
  logic [31:0] slow_addrs[$];

  mini_mcu_top #(
    .NUM_BYTES(NUM_BYTES)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_i),
    .instr_resp_o(instr_resp_o),
    .data_req_i  (data_req_i),
    .data_resp_o (data_resp_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  initial clk_i = 1'b0;
  always #HALF_PERIOD clk_i = ~clk_i;

  // sample 10 ns ahead of the rising edge
  always begin
    @(negedge clk_i);
    #SAMPLE_DLY;
    -> sample_ev;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish in %0d cycles, %0d errors", cycle_cnt, error_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  be);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return word;
  endfunction

  // address map model that checks only fully known words
  function automatic exp_t ref_access(input logic we, input logic [3:0] be,
                                      input logic [31:0] addr, input logic [31:0] wdata);
    exp_t        e;
    logic [29:0] key;
    e   = '0;
    key = addr[31:2];
    if (addr < 32'(NUM_BYTES) || addr[31:12] == 20'h30000) begin
      e.due_min = 2;
      e.due_max = (addr[31:12] == 20'h30000) ? 5 : 2;
      if (we) begin
        if (mem_m.exists(key)) begin
          mem_m[key] = merge_bytes(mem_m[key], wdata, be);
        end else if (be == 4'hF) begin
          mem_m[key] = wdata;
        end
      end else if (mem_m.exists(key)) begin
        e.chk_data = 1'b1;
        e.rdata    = mem_m[key];
      end
    end else if (addr[31:12] == 20'h20000) begin
      e.due_min  = 2;
      e.due_max  = 2;
      e.chk_data = !we;
      if (addr[11:0] == 12'h000) begin
        e.rdata = exit_value_m;
        if (we) begin
          exit_value_m = wdata;
        end
      end else if (addr[11:0] == 12'h004) begin
        e.rdata = {31'd0, exit_valid_m};
        if (we) begin
          exit_valid_m = wdata[0];
        end
      end
    end else begin
      e.due_min  = 1;
      e.due_max  = 1;
      e.err      = 1'b1;
      e.chk_data = !we;
      e.rdata    = EXP_ERR_RDATA;
    end
    return e;
  endfunction

  function automatic void check_value(input string what, input logic [31:0] expected,
                                      input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected) else begin
      $display("FAILED %s: %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
      error_cnt++;
    end
  endfunction

  function automatic void check_reset_state();
    check_value("instr gnt/rvalid", 32'd0, {30'd0, instr_resp_o.gnt, instr_resp_o.rvalid});
    check_value("data gnt/rvalid", 32'd0, {30'd0, data_resp_o.gnt, data_resp_o.rvalid});
    check_value("exit_valid_o", 32'd0, {31'd0, exit_valid_o});
    check_value("exit_value_o", 32'd0, exit_value_o);
  endfunction

  function automatic void check_response(input logic mid, input obi_resp_t rsp);
    exp_t  e;
    string port;
    port = mid ? "data" : "instr";
    if (rsp.rvalid) begin
      if ((mid && data_q.size() == 0) || (!mid && instr_q.size() == 0)) begin
        $display("ERROR %s: rvalid on the %s port with no request outstanding",
                 test_name, port);
        error_cnt++;
      end else begin
        if (mid) begin
          e = data_q.pop_front();
        end else begin
          e = instr_q.pop_front();
        end
        check_cnt++;
        assert (rsp.err === e.err) else begin
          $display("FAILED %s: %s port err expected %0b actual %0b",
                   test_name, port, e.err, rsp.err);
          error_cnt++;
        end
        assert (!e.chk_data || rsp.rdata === e.rdata) else begin
          $display("FAILED %s: %s port rdata expected 0x%08h actual 0x%08h",
                   test_name, port, e.rdata, rsp.rdata);
          error_cnt++;
        end
        assert (cycle_cnt >= e.due_min && cycle_cnt <= e.due_max) else begin
          $display("FAILED %s: %s port rvalid cycle expected %0d..%0d actual %0d",
                   test_name, port, e.due_min, e.due_max, cycle_cnt);
          error_cnt++;
        end
      end
    end
  endfunction

  // a tie goes to the master that was not served last
  function automatic void check_round_robin();
    logic any_gnt;
    logic tie;
    any_gnt = instr_resp_o.gnt || data_resp_o.gnt;
    tie     = instr_req_i.req && data_req_i.req;
    if (any_gnt && tie) begin
      tie_cnt++;
      if (have_last) begin
        assert (data_resp_o.gnt != last_mid) else begin
          $display("FAILED %s: tie winner mid expected %0b actual %0b",
                   test_name, !last_mid, data_resp_o.gnt);
          error_cnt++;
        end
      end
    end
    if (any_gnt && !tie) begin
      have_last = 1'b1;
      last_mid  = data_req_i.req;
    end else if (any_gnt && have_last) begin
      last_mid = !last_mid;
    end
  endfunction

  always @(sample_ev) begin
    check_response(1'b0, instr_resp_o);
    check_response(1'b1, data_resp_o);
    check_round_robin();
  end

  task automatic drive_master(input logic mid, input obi_req_t req);
    if (mid) begin
      data_req_i = req;
    end else begin
      instr_req_i = req;
    end
  endtask

  // hold the request until gnt and wait for the single rvalid
  task automatic obi_access(input logic mid, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata);
    exp_t      e;
    obi_resp_t rsp;
    logic      granted;
    logic      done;
    granted = 1'b0;
    done    = 1'b0;
    @(negedge clk_i);
    drive_master(mid, '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata});
    while (!granted) begin
      @(sample_ev);
      rsp = mid ? data_resp_o : instr_resp_o;
      if (rsp.gnt) begin
        granted   = 1'b1;
        e         = ref_access(we, be, addr, wdata);
        e.due_min = e.due_min + cycle_cnt;
        e.due_max = e.due_max + cycle_cnt;
        if (mid) begin
          data_q.push_back(e);
        end else begin
          instr_q.push_back(e);
        end
      end
    end
    @(negedge clk_i);
    drive_master(mid, '0);
    while (!done) begin
      @(sample_ev);
      rsp  = mid ? data_resp_o : instr_resp_o;
      done = rsp.rvalid;
    end
  endtask

  task automatic instr_access(input logic [31:0] addr);
    obi_access(1'b0, 1'b0, 4'hF, addr, 32'd0);
  endtask

  task automatic data_access(input logic we, input logic [3:0] be,
                             input logic [31:0] addr, input logic [31:0] wdata);
    obi_access(1'b1, we, be, addr, wdata);
  endtask

  task automatic check_drained();
    @(negedge clk_i);
    if (instr_q.size() != 0 || data_q.size() != 0) begin
      $display("ERROR %s: %0d instr and %0d data responses never arrived",
               test_name, instr_q.size(), data_q.size());
      error_cnt++;
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    int          ties_before;
    seed         = 99;
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    test_name    = "reset";
    rst_n_i      = 1'b0;
    instr_req_i  = '0;
    data_req_i   = '0;
    @(sample_ev);
    check_reset_state();
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(sample_ev);
    check_reset_state();

    // full and partial writes with read back in alternating banks
    test_name = "ram_write_read";
    for (int i = 0; i < 32; i++) begin
      rnd  = $random(seed);
      addr = {20'd0, i[0], rnd[10:2], 2'b00};
      ram_addrs.push_back(addr);
      data_access(1'b1, 4'hF, addr, $random(seed));
      rnd = $random(seed);
      data_access(1'b1, rnd[3:0], addr, $random(seed));
      data_access(1'b0, 4'hF, addr, 32'd0);
    end
    foreach (ram_addrs[i]) begin
      instr_access(ram_addrs[i]);
    end
    check_drained();

    test_name = "slow_mem";
    for (int i = 0; i < 32; i++) begin
      rnd  = $random(seed);
      addr = SLOW_BASE | {23'd0, rnd[8:2], 2'b00};
      slow_addrs.push_back(addr);
      data_access(1'b1, 4'hF, addr, $random(seed));
      rnd = $random(seed);
      data_access(1'b1, rnd[3:0], addr, $random(seed));
      data_access(1'b0, 4'hF, addr, 32'd0);
    end
    check_drained();

    // RAM and slow memory in parallel and later both masters on RAM
    test_name   = "concurrent";
    ties_before = tie_cnt;
    fork
      begin
        for (int i = 0; i < 24; i++) begin
          instr_access(ram_addrs[i]);
        end
      end
      begin
        for (int i = 0; i < 24; i++) begin
          data_access(!i[0], 4'hF, slow_addrs[i / 2], $random(seed));
        end
      end
    join
    fork
      begin
        for (int i = 0; i < 16; i++) begin
          instr_access(ram_addrs[i]);
        end
      end
      begin
        for (int i = 0; i < 16; i++) begin
          data_access(1'b0, 4'hF, ram_addrs[31 - i], 32'd0);
        end
      end
    join
    check_drained();
    assert (tie_cnt > ties_before) else begin
      $display("ERROR %s: the two masters never requested in the same cycle", test_name);
      error_cnt++;
    end

    // writes to the unmapped alias must leave RAM alone
    test_name = "unmapped";
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      data_access(1'b1, 4'hF, ram_addrs[i] | 32'h0000_1000, rnd);
      data_access(1'b0, 4'hF, 32'h4000_0000 | {20'd0, rnd[11:2], 2'b00}, 32'd0);
      instr_access(32'h1000_0000 | {20'd0, rnd[11:2], 2'b00});
      data_access(1'b0, 4'hF, ram_addrs[i], 32'd0);
    end
    check_drained();

    test_name = "exit_regs";
    data_access(1'b1, 4'hF, PERIPH_BASE, $random(seed));
    check_value("exit_value_o", exit_value_m, exit_value_o);
    check_value("exit_valid_o", {31'd0, exit_valid_m}, {31'd0, exit_valid_o});
    data_access(1'b1, 4'hF, PERIPH_BASE | 32'h4, 32'h1);
    check_value("exit_valid_o", {31'd0, exit_valid_m}, {31'd0, exit_valid_o});
    data_access(1'b0, 4'hF, PERIPH_BASE, 32'd0);
    data_access(1'b0, 4'hF, PERIPH_BASE | 32'h4, 32'd0);
    check_drained();

    $display("%0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- flist.f
src/mini_mcu_pkg.sv
src/obi_master_arbiter.sv
src/obi_addr_decoder.sv
src/memory_subsystem.sv
src/peripheral_subsystem.sv
src/slow_memory.sv
src/mini_mcu_top.sv
dv/tb_mini_mcu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the result from the log
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mini_mcu \
  -f flist.f \
  -o sim_mini_mcu

./obj_dir/sim_mini_mcu | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi
